// File: testbench/eq_stim.txt
# name mode(0 const,1 random,2 random+reset) lts_i lts_q dat_i dat_q nsym gap
# exp data ref0 i q, exp data ref1 i q, exp pilot sum pol0 i q, exp pilot sum pol1 i q
const_a 0 1024 0 512 256 2 0 128 64 -128 -64 0 0 0 0
const_b 0 -2048 1024 300 -700 2 1 -325 275 325 -275 0 0 0 0
rand_prod 1 0 0 0 0 3 0 0 0 0 0 0 0 0 0
polarity 1 0 0 0 0 5 0 0 0 0 0 0 0 0 0
gaps 1 0 0 0 0 3 1 0 0 0 0 0 0 0 0
reset_mid 2 0 0 0 0 1 0 0 0 0 0 0 0 0 0

// File: compile.f
rtl/eq_pkg.sv
rtl/symbol_sequencer.sv
rtl/lts_average.sv
rtl/pilot_polarity.sv
rtl/eq_correct.sv
rtl/ofdm_equalizer.sv
testbench/ofdm_equalizer_chk.sv
testbench/tb_ofdm_equalizer.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ofdm_equalizer
FILELIST = compile.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^sim passed$$"

clean:
	rm -rf $(OBJDIR)

// File: testbench/tb_ofdm_equalizer.sv
`timescale 1ns/100ps

module tb_ofdm_equalizer
    import eq_pkg::*;
();

    localparam int SHIFT   = 12;
    localparam int MAX_REC = 8;
    localparam int OUT_LAT = 5;   // drive edge to the edge that sees sample_out_strobe_o
    localparam int SUM_LAT = 6;

    typedef struct packed {
        int                     cyc;
        logic signed [IQ_W-1:0] i;
        logic signed [IQ_W-1:0] q;
    } out_exp_t;

    typedef struct packed {
        int                       cyc;
        logic signed [PROD_W-1:0] i;
        logic signed [PROD_W-1:0] q;
    } sum_exp_t;

    logic       clock;
    logic       reset;
    iq_t        sample_in_i;
    logic       sample_in_strobe_i;
    iq_t        sample_out_o;
    logic       sample_out_strobe_o;
    phase_sum_t phase_o;
    logic       phase_stb_o;

    int       cyc = 0;
    int       err_value = 0;
    int       err_other = 0;
    logic     checking = 1'b0;
    longint   wd_ns = 0;
    string    cur_name = "";
    out_exp_t out_q[$];
    sum_exp_t sum_q[$];
    out_exp_t mon_out;
    sum_exp_t mon_sum;

    // test records from the stim file
    logic [255:0] rec_name [MAX_REC];
    int rec_mode [MAX_REC];
    int rec_lts_i [MAX_REC];
    int rec_lts_q [MAX_REC];
    int rec_dat_i [MAX_REC];
    int rec_dat_q [MAX_REC];
    int rec_nsym [MAX_REC];
    int rec_gap [MAX_REC];
    int rec_d0i [MAX_REC];
    int rec_d0q [MAX_REC];
    int rec_d1i [MAX_REC];
    int rec_d1q [MAX_REC];
    int rec_p0i [MAX_REC];
    int rec_p0q [MAX_REC];
    int rec_p1i [MAX_REC];
    int rec_p1q [MAX_REC];
    int num_rec = 0;

    // model state
    int est_i [NUM_SC];
    int est_q [NUM_SC];
    int lts_i [NUM_SC];
    int lts_q [NUM_SC];
    int sym_count;

    ofdm_equalizer #(
        .PROD_SHIFT (SHIFT)
    ) u_dut (
        .clock               (clock),
        .reset               (reset),
        .sample_in_i         (sample_in_i),
        .sample_in_strobe_i  (sample_in_strobe_i),
        .sample_out_o        (sample_out_o),
        .sample_out_strobe_o (sample_out_strobe_o),
        .phase_o             (phase_o),
        .phase_stb_o         (phase_stb_o)
    );

    always #20 clock = ~clock;

    always @(posedge clock) cyc <= cyc + 1;

    //////////////////////////////////////////////////
    // stimulus helpers

    function automatic int pick(input int r, input int cval);
        if (rec_mode[r] == 0) return cval;
        return int'($urandom_range(4094)) - 2047;   // amplitude below 2^11
    endfunction

    task automatic apply_reset();
        @(posedge clock);
        reset              <= 1'b1;
        sample_in_strobe_i <= 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic send_sample(input int si, input int sq, input int gap, output int at_cyc);
        int idle;
        idle = (gap != 0) ? int'($urandom_range(1)) : 0;
        repeat (idle) begin
            @(posedge clock);
            sample_in_strobe_i <= 1'b0;
        end
        @(posedge clock);
        sample_in_i.i      <= IQ_W'(si);
        sample_in_i.q      <= IQ_W'(sq);
        sample_in_strobe_i <= 1'b1;
        at_cyc = cyc;
    endtask

    task automatic stop_input();
        @(posedge clock);
        sample_in_strobe_i <= 1'b0;
    endtask

    task automatic wait_drain();
        while (out_q.size() != 0 || sum_q.size() != 0) @(posedge clock);
        repeat (8) @(posedge clock);
    endtask

    //////////////////////////////////////////////////
    // one frame: two LTS symbols and the data symbols, with the model

    task automatic run_frame(input int r);
        int       k;
        int       n;
        int       at;
        int       si;
        int       sq;
        int       avg_i;
        int       avg_q;
        logic signed [PROD_W-1:0] prod_i;
        logic signed [PROD_W-1:0] prod_q;
        logic signed [PROD_W-1:0] acc_i;
        logic signed [PROD_W-1:0] acc_q;
        out_exp_t oe;
        sum_exp_t se;
        logic     pol;
        logic     neg;
        for (k = 0; k < NUM_SC; k++) begin
            lts_i[k] = pick(r, rec_lts_i[r]);
            lts_q[k] = pick(r, rec_lts_q[r]);
            send_sample(lts_i[k], lts_q[k], rec_gap[r], at);
        end
        for (k = 0; k < NUM_SC; k++) begin
            si    = pick(r, rec_lts_i[r]);
            sq    = pick(r, rec_lts_q[r]);
            avg_i = (lts_i[k] + si) >>> 1;
            avg_q = (lts_q[k] + sq) >>> 1;
            est_i[k] = LTS_REF[k] ? -avg_i : avg_i;
            est_q[k] = LTS_REF[k] ? -avg_q : avg_q;
            send_sample(si, sq, rec_gap[r], at);
        end
        for (n = 0; n < rec_nsym[r]; n++) begin
            acc_i = '0;
            acc_q = '0;
            pol   = POLARITY[sym_count % 127];
            for (k = 0; k < NUM_SC; k++) begin
                si = pick(r, rec_dat_i[r]);
                sq = pick(r, rec_dat_q[r]);
                send_sample(si, sq, rec_gap[r], at);
                prod_i = PROD_W'(si * est_i[k] + sq * est_q[k]);   // x * conj(h)
                prod_q = PROD_W'(sq * est_i[k] - si * est_q[k]);
                if (DATA_SC_MASK[k]) begin
                    oe.cyc = at + OUT_LAT;
                    oe.i   = prod_i[SHIFT +: IQ_W];
                    oe.q   = prod_q[SHIFT +: IQ_W];
                    out_q.push_back(oe);
                    if (rec_mode[r] == 0) begin
                        if (oe.i != IQ_W'(LTS_REF[k] ? rec_d1i[r] : rec_d0i[r]) ||
                            oe.q != IQ_W'(LTS_REF[k] ? rec_d1q[r] : rec_d0q[r])) begin
                            err_value++;
                            $display("Fail %s model at sc %0d: expected %0d,%0d actual %0d,%0d",
                                cur_name, k, LTS_REF[k] ? rec_d1i[r] : rec_d0i[r],
                                LTS_REF[k] ? rec_d1q[r] : rec_d0q[r], oe.i, oe.q);
                        end
                    end
                end
                if (PILOT_MASK[k]) begin
                    neg   = (k == 21) ? ~pol : pol;
                    acc_i = neg ? acc_i - prod_i : acc_i + prod_i;
                    acc_q = neg ? acc_q - prod_q : acc_q + prod_q;
                end
            end
            se.cyc = at + SUM_LAT;
            se.i   = acc_i;
            se.q   = acc_q;
            sum_q.push_back(se);
            if (rec_mode[r] == 0) begin
                if (acc_i != PROD_W'(pol ? rec_p1i[r] : rec_p0i[r]) ||
                    acc_q != PROD_W'(pol ? rec_p1q[r] : rec_p0q[r])) begin
                    err_value++;
                    $display("Fail %s model pilot sum: expected %0d,%0d actual %0d,%0d",
                        cur_name, pol ? rec_p1i[r] : rec_p0i[r],
                        pol ? rec_p1q[r] : rec_p0q[r], acc_i, acc_q);
                end
            end
            sym_count++;
        end
        stop_input();
    endtask

    task automatic run_test(input int r);
        int k;
        int at;
        cur_name  = $sformatf("%0s", rec_name[r]);
        sym_count = 0;
        checking  = 1'b1;
        apply_reset();
        run_frame(r);
        wait_drain();
        if (rec_mode[r] == 2) begin
            // break off a data symbol halfway, then start over from the first LTS
            checking = 1'b0;
            for (k = 0; k < NUM_SC / 2; k++) begin
                send_sample(pick(r, 0), pick(r, 0), 0, at);
            end
            stop_input();
            repeat (8) @(posedge clock);
            apply_reset();
            sym_count = 0;
            checking  = 1'b1;
            run_frame(r);
            wait_drain();
        end
    endtask

    //////////////////////////////////////////////////
    // output monitor, samples values that settled before the edge

    always @(posedge clock) begin
        if (!reset && checking) begin
            if (sample_out_strobe_o) begin
                if (out_q.size() == 0) begin
                    err_other++;
                    $display("Error %s: output strobe with no sample expected", cur_name);
                end else begin
                    mon_out = out_q.pop_front();
                    if (mon_out.cyc != cyc) begin
                        err_value++;
                        $display("Fail %s output cycle: expected %0d actual %0d",
                            cur_name, mon_out.cyc, cyc);
                    end
                    if (sample_out_o.i != mon_out.i || sample_out_o.q != mon_out.q) begin
                        err_value++;
                        $display("Fail %s sample_out_o: expected %0d,%0d actual %0d,%0d",
                            cur_name, mon_out.i, mon_out.q, sample_out_o.i, sample_out_o.q);
                    end
                end
            end
            if (phase_stb_o) begin
                if (sum_q.size() == 0) begin
                    err_other++;
                    $display("Error %s: phase strobe with no pilot sum expected", cur_name);
                end else begin
                    mon_sum = sum_q.pop_front();
                    if (mon_sum.cyc != cyc) begin
                        err_value++;
                        $display("Fail %s phase cycle: expected %0d actual %0d",
                            cur_name, mon_sum.cyc, cyc);
                    end
                    if (phase_o.i != mon_sum.i || phase_o.q != mon_sum.q) begin
                        err_value++;
                        $display("Fail %s phase_o: expected %0d,%0d actual %0d,%0d",
                            cur_name, mon_sum.i, mon_sum.q, phase_o.i, phase_o.q);
                    end
                end
            end
        end
    end

    // watchdog, armed once the stim file is read
    initial begin
        wait (wd_ns != 0);
        #(wd_ns);
        $display("Error: watchdog timeout, the run did not finish in time");
        $display("sim failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        int     fd;
        int     r;
        int     cnt;
        longint samples;
        string  line;
        clock              = 1'b0;
        reset              = 1'b1;
        sample_in_i        = '0;
        sample_in_strobe_i = 1'b0;
        void'($urandom(32'hcc80_e83c));
        samples = 0;
        fd = $fopen("testbench/eq_stim.txt", "r");
        if (fd == 0) begin
            err_other++;
            $display("Error: cannot open testbench/eq_stim.txt");
        end else begin
            while (!$feof(fd) && num_rec < MAX_REC) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    r   = num_rec;
                    cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        rec_name[r], rec_mode[r], rec_lts_i[r], rec_lts_q[r], rec_dat_i[r],
                        rec_dat_q[r], rec_nsym[r], rec_gap[r], rec_d0i[r], rec_d0q[r],
                        rec_d1i[r], rec_d1q[r], rec_p0i[r], rec_p0q[r], rec_p1i[r], rec_p1q[r]);
                    if (cnt == 16) begin
                        num_rec++;
                        samples += NUM_SC * (2 + rec_nsym[r]);
                        if (rec_mode[r] == 2) samples += NUM_SC * (2 + rec_nsym[r]) + NUM_SC / 2;
                    end
                end
            end
            $fclose(fd);
        end
        if (num_rec == 0) begin
            err_other++;
            $display("Error: no test records found in the stim file");
        end
        wd_ns = samples * 3 * 40 + longint'(num_rec) * 2000 * 40 + 4000;
        for (r = 0; r < num_rec; r++) begin
            run_test(r);
        end
        $display("errors: %0d value, %0d other", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: testbench/ofdm_equalizer_chk.sv
`timescale 1ns/100ps

module ofdm_equalizer_chk (
    input logic clock,
    input logic reset,
    input logic sample_in_strobe_i,
    input logic sample_out_strobe_o,
    input logic phase_stb_o
);

    //////////////////////////////////////////////////
    // strobe shape and latency

    a_phase_pulse : assert property (
        @(posedge clock) disable iff (reset)
        phase_stb_o |=> !phase_stb_o
    ) else $error("phase_stb_o held high for two cycles");

    // sequencer, estimate read, product and output register
    a_out_latency : assert property (
        @(posedge clock) disable iff (reset)
        sample_out_strobe_o |-> $past(sample_in_strobe_i, 4)
    ) else $error("sample_out_strobe_o without an input strobe 4 cycles before");

    a_quiet_reset : assert property (
        @(posedge clock)
        reset |=> (!sample_out_strobe_o && !phase_stb_o)
    ) else $error("output strobe high during reset");

endmodule

bind ofdm_equalizer ofdm_equalizer_chk u_chk (.*);

// File: rtl/ofdm_equalizer.sv
`timescale 1ns/100ps

module ofdm_equalizer
    import eq_pkg::*;
#(
    parameter int PROD_SHIFT = 12   // 0 to 16
) (
    input  logic       clock,
    input  logic       reset,
    input  iq_t        sample_in_i,
    input  logic       sample_in_strobe_i,
    output iq_t        sample_out_o,
    output logic       sample_out_strobe_o,
    output phase_sum_t phase_o,
    output logic       phase_stb_o
);

    sc_beat_t    beat;
    est_beat_t   est;
    pilot_info_t pilot;

    symbol_sequencer u_symbol_sequencer (
        .clock              (clock),
        .reset              (reset),
        .sample_in_i        (sample_in_i),
        .sample_in_strobe_i (sample_in_strobe_i),
        .beat_o             (beat)
    );

    // estimate and pilot sign run side by side, both one cycle
    lts_average u_lts_average (
        .clock  (clock),
        .reset  (reset),
        .beat_i (beat),
        .est_o  (est)
    );

    pilot_polarity u_pilot_polarity (
        .clock   (clock),
        .reset   (reset),
        .beat_i  (beat),
        .pilot_o (pilot)
    );

    eq_correct #(
        .PROD_SHIFT (PROD_SHIFT)
    ) u_eq_correct (
        .clock               (clock),
        .reset               (reset),
        .est_i               (est),
        .pilot_i             (pilot),
        .sample_out_o        (sample_out_o),
        .sample_out_strobe_o (sample_out_strobe_o),
        .phase_o             (phase_o),
        .phase_stb_o         (phase_stb_o)
    );

endmodule

// File: rtl/eq_correct.sv
`timescale 1ns/100ps

module eq_correct
    import eq_pkg::*;
#(
    parameter int PROD_SHIFT = 12
) (
    input  logic        clock,
    input  logic        reset,
    input  est_beat_t   est_i,
    input  pilot_info_t pilot_i,
    output iq_t         sample_out_o,
    output logic        sample_out_strobe_o,
    output phase_sum_t  phase_o,
    output logic        phase_stb_o
);

    logic       data_beat;
    phase_sum_t prod_q;        // sample * conj(est)
    logic       prod_vld;
    logic       prod_data;
    logic       prod_pilot;
    logic       prod_neg;
    logic       prod_last;
    logic       prod_first;
    phase_sum_t addend;
    phase_sum_t acc_q;
    logic       last_q;

    assign data_beat = est_i.beat.valid && (est_i.beat.stage == STAGE_DATA);

    //////////////////////////////////////////////////
    // conjugate product, cycle 2

    always_ff @(posedge clock) begin
        prod_q.i <= est_i.beat.sample.i * est_i.est.i + est_i.beat.sample.q * est_i.est.q;
        prod_q.q <= est_i.beat.sample.q * est_i.est.i - est_i.beat.sample.i * est_i.est.q;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            prod_vld   <= 1'b0;
            prod_data  <= 1'b0;
            prod_pilot <= 1'b0;
            prod_neg   <= 1'b0;
            prod_last  <= 1'b0;
            prod_first <= 1'b0;
        end else begin
            prod_vld   <= data_beat;
            prod_data  <= data_beat && DATA_SC_MASK[est_i.beat.index];
            prod_pilot <= pilot_i.is_pilot;
            prod_neg   <= pilot_i.negate;
            prod_last  <= pilot_i.last;
            prod_first <= data_beat && (est_i.beat.index == '0);
        end
    end

    //////////////////////////////////////////////////
    // output slice and pilot sum, cycle 3

    always_comb begin
        addend = '0;
        if (prod_pilot) begin
            addend.i = prod_neg ? -prod_q.i : prod_q.i;
            addend.q = prod_neg ? -prod_q.q : prod_q.q;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            sample_out_o        <= '0;
            sample_out_strobe_o <= 1'b0;
            acc_q               <= '0;
            last_q              <= 1'b0;
        end else begin
            sample_out_strobe_o <= prod_data;
            if (prod_data) begin
                sample_out_o.i <= prod_q.i[PROD_SHIFT +: IQ_W];
                sample_out_o.q <= prod_q.q[PROD_SHIFT +: IQ_W];
            end
            if (prod_vld) begin
                // index 0 restarts the sum for a new symbol
                acc_q.i <= (prod_first ? '0 : acc_q.i) + addend.i;
                acc_q.q <= (prod_first ? '0 : acc_q.q) + addend.q;
            end
            last_q <= prod_vld && prod_last;
        end
    end

    // publish one cycle after the symbol's last beat, cycle 4
    always_ff @(posedge clock) begin
        if (reset) begin
            phase_o     <= '0;
            phase_stb_o <= 1'b0;
        end else begin
            phase_stb_o <= last_q;
            if (last_q) phase_o <= acc_q;
        end
    end

endmodule

// File: rtl/pilot_polarity.sv
`timescale 1ns/100ps

module pilot_polarity
    import eq_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  sc_beat_t    beat_i,
    output pilot_info_t pilot_o
);

    logic [126:0] polarity_q;
    logic         data_beat;
    logic         sym_end;
    logic         sign_bit;

    assign data_beat = beat_i.valid && (beat_i.stage == STAGE_DATA);
    assign sym_end   = data_beat && (beat_i.index == SC_IDX_W'(NUM_SC - 1));

    // pilot 21 takes the inverted sequence bit
    assign sign_bit = (beat_i.index == SC_IDX_W'(21)) ? ~polarity_q[0] : polarity_q[0];

    //////////////////////////////////////////////////
    // polarity sequence, one bit per data symbol

    always_ff @(posedge clock) begin
        if (reset) begin
            polarity_q <= POLARITY;
        end else if (sym_end) begin
            polarity_q <= {polarity_q[0], polarity_q[126:1]};   // rotate right
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pilot_o <= '0;
        end else begin
            pilot_o.is_pilot <= data_beat && PILOT_MASK[beat_i.index];
            pilot_o.negate   <= data_beat && PILOT_MASK[beat_i.index] && sign_bit;
            pilot_o.last     <= sym_end;
        end
    end

endmodule

// File: rtl/lts_average.sv
`timescale 1ns/100ps

module lts_average
    import eq_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  sc_beat_t  beat_i,
    output est_beat_t est_o
);

    iq_t mem [NUM_SC];   // channel estimate, one entry per subcarrier

    logic signed [IQ_W:0]   sum_i;
    logic signed [IQ_W:0]   sum_q;
    logic signed [IQ_W-1:0] avg_i;
    logic signed [IQ_W-1:0] avg_q;
    iq_t                    new_est;
    logic                   first_wr;
    logic                   second_wr;
    logic [SC_IDX_W-1:0]    wr_addr;
    iq_t                    wr_data;

    //////////////////////////////////////////////////
    // average of stored first LTS and second LTS

    // est_o.est holds the first LTS while a second LTS beat sits in est_o
    assign sum_i = est_o.est.i + est_o.beat.sample.i;
    assign sum_q = est_o.est.q + est_o.beat.sample.q;
    assign avg_i = IQ_W'(sum_i >>> 1);
    assign avg_q = IQ_W'(sum_q >>> 1);

    always_comb begin
        if (LTS_REF[est_o.beat.index]) begin
            new_est.i = -avg_i;
            new_est.q = -avg_q;
        end else begin
            new_est.i = avg_i;
            new_est.q = avg_q;
        end
    end

    assign first_wr  = beat_i.valid && (beat_i.stage == STAGE_FIRST_LTS);
    assign second_wr = est_o.beat.valid && (est_o.beat.stage == STAGE_SECOND_LTS);

    // the two write sources never overlap, second LTS follows the first
    assign wr_addr = second_wr ? est_o.beat.index : beat_i.index;
    assign wr_data = second_wr ? new_est : beat_i.sample;

    always_ff @(posedge clock) begin
        if (first_wr || second_wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, aligned with the delayed beat
    always_ff @(posedge clock) begin
        if (reset) begin
            est_o <= '0;
        end else begin
            est_o.beat <= beat_i;
            est_o.est  <= mem[beat_i.index];
        end
    end

endmodule

// File: rtl/symbol_sequencer.sv
`timescale 1ns/100ps

module symbol_sequencer
    import eq_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  iq_t      sample_in_i,
    input  logic     sample_in_strobe_i,
    output sc_beat_t beat_o
);

    frame_stage_e        stage_q;
    logic [SC_IDX_W-1:0] index_q;
    logic                wrap;

    assign wrap = (index_q == SC_IDX_W'(NUM_SC - 1));

    //////////////////////////////////////////////////
    // subcarrier counter and frame stage

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_q <= STAGE_FIRST_LTS;
            index_q <= '0;
        end else if (sample_in_strobe_i) begin
            index_q <= index_q + 1'b1;   // wraps to 0 after 63
            if (wrap) begin
                case (stage_q)
                    STAGE_FIRST_LTS:  stage_q <= STAGE_SECOND_LTS;
                    STAGE_SECOND_LTS: stage_q <= STAGE_DATA;
                    default:          stage_q <= STAGE_DATA; // data symbols repeat
                endcase
            end
        end
    end

    // tag each accepted sample with its stage and index
    always_ff @(posedge clock) begin
        if (reset) begin
            beat_o <= '0;
        end else begin
            beat_o.valid  <= sample_in_strobe_i;
            beat_o.stage  <= stage_q;
            beat_o.index  <= index_q;
            beat_o.sample <= sample_in_i;
        end
    end

endmodule

// File: rtl/eq_pkg.sv
package eq_pkg;

    localparam int NUM_SC   = 64;
    localparam int SC_IDX_W = 6;
    localparam int IQ_W     = 16;
    localparam int PROD_W   = 32;

    // bit k is subcarrier k, bit 0 is DC, upper half holds the negative subcarriers
    localparam logic [NUM_SC-1:0] LTS_REF =
        64'b0000101001100000010100110000000000000000010101100111110101001100;

    localparam logic [NUM_SC-1:0] USED_SC_MASK =
        64'b1111111111111111111111111100000000000111111111111111111111111110;

    localparam logic [NUM_SC-1:0] PILOT_MASK =
        (64'd1 << 7) | (64'd1 << 21) | (64'd1 << 43) | (64'd1 << 57);

    localparam logic [NUM_SC-1:0] DATA_SC_MASK = USED_SC_MASK ^ PILOT_MASK;

    // pilot polarity, bit 0 goes with the first data symbol
    localparam logic [126:0] POLARITY =
        127'b1111111000111011000101001011111010101000010110111100111001010110011000001101101011101000110010001000000100100110100111101110000;

    typedef enum logic [1:0] {
        STAGE_FIRST_LTS  = 2'd0,
        STAGE_SECOND_LTS = 2'd1,
        STAGE_DATA       = 2'd2
    } frame_stage_e;

    typedef struct packed {
        logic signed [IQ_W-1:0] i;
        logic signed [IQ_W-1:0] q;
    } iq_t;

    typedef struct packed {
        logic                valid;
        frame_stage_e        stage;
        logic [SC_IDX_W-1:0] index;
        iq_t                 sample;
    } sc_beat_t;

    typedef struct packed {
        sc_beat_t beat;
        iq_t      est;
    } est_beat_t;

    typedef struct packed {
        logic is_pilot;
        logic negate;
        logic last;   // index 63 of a data symbol
    } pilot_info_t;

    typedef struct packed {
        logic signed [PROD_W-1:0] i;
        logic signed [PROD_W-1:0] q;
    } phase_sum_t;

endpackage
